/* design/zc_geom_pkg.sv */
`default_nettype none

package zc_geom_pkg;

    // Default frame size in pixels
    localparam int default_img_width  = 32;
    localparam int default_img_height = 24;

    localparam int nbr_count = 8;

    // Neighbour probe order
    // up-left, up, up-right, left, right, down-left, down, down-right
    localparam int nbr_dx [nbr_count] = '{-1,  0,  1, -1,  1, -1,  0,  1};
    localparam int nbr_dy [nbr_count] = '{-1, -1, -1,  0,  0,  1,  1,  1};

endpackage

`default_nettype wire

/* design/zc_cfg_pkg.sv */
`default_nettype none

package zc_cfg_pkg;

    localparam int cfg_data_width = 16;

    typedef logic [1:0] cfg_addr_t;

    // Register map
    localparam cfg_addr_t reg_border      = 2'd0;
    localparam cfg_addr_t reg_min_edge    = 2'd1;
    localparam cfg_addr_t reg_min_stripes = 2'd2;

    // Values after reset
    localparam logic [cfg_data_width-1:0] rst_border      = 16'd2;
    localparam logic [cfg_data_width-1:0] rst_min_edge    = 16'd12;
    localparam logic [cfg_data_width-1:0] rst_min_stripes = 16'd3;

endpackage

`default_nettype wire

/* design/zc_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module zc_cfg_regs (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  cfg_we,
    input  zc_cfg_pkg::cfg_addr_t                 cfg_addr,
    input  logic [zc_cfg_pkg::cfg_data_width-1:0] cfg_wdata,
    output logic [zc_cfg_pkg::cfg_data_width-1:0] cfg_rdata,
    output logic [zc_cfg_pkg::cfg_data_width-1:0] border,
    output logic [zc_cfg_pkg::cfg_data_width-1:0] min_edge_length,
    output logic [zc_cfg_pkg::cfg_data_width-1:0] min_stripes
);
    import zc_cfg_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            border          <= rst_border;
            min_edge_length <= rst_min_edge;
            min_stripes     <= rst_min_stripes;
        end else if (cfg_we) begin
            case (cfg_addr)
                reg_border:      border          <= cfg_wdata;
                reg_min_edge:    min_edge_length <= cfg_wdata;
                reg_min_stripes: min_stripes     <= cfg_wdata;
                default: ;
            endcase
        end
    end

    // Unmapped addresses read as zero
    always_comb begin
        case (cfg_addr)
            reg_border:      cfg_rdata = border;
            reg_min_edge:    cfg_rdata = min_edge_length;
            reg_min_stripes: cfg_rdata = min_stripes;
            default:         cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/frame_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_loader #(
    parameter int img_width    = zc_geom_pkg::default_img_width,
    parameter int img_height   = zc_geom_pkg::default_img_height,
    parameter int credit_count = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    pix_valid,
    input  logic                                    pix_data,
    output logic                                    credit_return,
    input  logic                                    detection_valid,
    output logic                                    frame_start,
    output logic [$clog2(img_width*img_height)-1:0] ram_addr,
    output logic                                    img_we,
    output logic                                    img_wdata,
    output logic                                    vis_we,
    output logic                                    vis_wdata
);
    localparam int frame_size = img_width * img_height;
    localparam int aw         = $clog2(frame_size);
    localparam int cw         = $clog2(credit_count + 1);
    localparam logic [aw-1:0] last_pix   = aw'(frame_size - 1);
    localparam logic [aw-1:0] first_held = aw'(frame_size - credit_count);

    logic [aw-1:0] pix_cnt;
    logic [cw-1:0] held_cnt;
    logic          releasing;
    logic          ret_pix;
    logic          hold_pix;
    logic          rel_go;

    // Credits of the frame tail stay here until the result is out
    assign ret_pix  = pix_valid && (pix_cnt < first_held);
    assign hold_pix = pix_valid && !ret_pix;
    assign rel_go   = (detection_valid || releasing) && (held_cnt != '0);

    assign ram_addr  = pix_cnt;
    assign img_we    = pix_valid;
    assign img_wdata = pix_data;
    assign vis_we    = pix_valid;
    assign vis_wdata = 1'b0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt       <= '0;
            held_cnt      <= '0;
            releasing     <= 1'b0;
            credit_return <= 1'b0;
            frame_start   <= 1'b0;
        end else begin
            credit_return <= ret_pix || rel_go;
            frame_start   <= pix_valid && (pix_cnt == last_pix);
            if (pix_valid) begin
                pix_cnt <= (pix_cnt == last_pix) ? '0 : pix_cnt + 1'b1;
            end
            // One pulse per cycle, an early pixel credit just stays in the pool
            held_cnt <= held_cnt + cw'(hold_pix) - cw'(rel_go && !ret_pix);
            if (detection_valid) begin
                releasing <= 1'b1;
            end else if (held_cnt == '0) begin
                releasing <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* design/bit_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module bit_ram #(
    parameter int depth = 768
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] addr,
    input  logic                     wdata,
    output logic                     rdata
);
    logic mem [depth];

    // Read returns the old content when written in the same cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

/* design/contour_tracer.sv */
`timescale 1ns/1ps
`default_nettype none

module contour_tracer #(
    parameter int img_width  = zc_geom_pkg::default_img_width,
    parameter int img_height = zc_geom_pkg::default_img_height
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    frame_start,
    input  logic [zc_cfg_pkg::cfg_data_width-1:0]   border,
    input  logic [zc_cfg_pkg::cfg_data_width-1:0]   min_edge_length,
    input  logic [zc_cfg_pkg::cfg_data_width-1:0]   min_stripes,
    output logic                                    busy,
    output logic [$clog2(img_width*img_height)-1:0] pixel_addr,
    input  logic                                    pixel_data,
    output logic [$clog2(img_width*img_height)-1:0] visited_addr,
    output logic                                    visited_we,
    output logic                                    visited_wdata,
    input  logic                                    visited_rdata,
    output logic                                    detection_valid,
    output logic                                    crossing_detected,
    output logic [7:0]                              stripe_count
);
    import zc_geom_pkg::*;
    import zc_cfg_pkg::*;

    localparam int aw = $clog2(img_width * img_height);
    localparam int xw = $clog2(img_width);
    localparam int yw = $clog2(img_height);

    typedef enum logic [2:0] {
        st_idle,
        st_wait_read,
        st_scan,
        st_check_nbr,
        st_follow_edge,
        st_report
    } state_t;

    state_t                    state;
    logic                      tracing;
    logic [aw-1:0]             rd_addr;
    logic [xw-1:0]             x_pos, x_edge, x_prev, x_start, sx_next;
    logic [yw-1:0]             y_pos, y_edge, y_prev, y_start, sy_next;
    logic [3:0]                nbr_idx;
    logic [15:0]               edge_len;
    logic [7:0]                num_stripes;
    logic [cfg_data_width-1:0] bdr_q, min_len_q, min_str_q;
    int                        lo, x_hi, y_hi, nx, ny, step_len, new_bdr;
    logic                      in_bounds, is_start, is_prev, scan_end, new_ok;

    function automatic logic [aw-1:0] addr_of(input int x, input int y);
        return aw'(y * img_width + x);
    endfunction

    always_comb begin
        lo        = int'(bdr_q);
        x_hi      = img_width - 1 - lo;
        y_hi      = img_height - 1 - lo;
        new_bdr   = int'(border);
        new_ok    = (2 * new_bdr < img_width) && (2 * new_bdr < img_height);
        nx        = int'(x_edge) + nbr_dx[nbr_idx[2:0]];
        ny        = int'(y_edge) + nbr_dy[nbr_idx[2:0]];
        in_bounds = (nx >= lo) && (nx <= x_hi) && (ny >= lo) && (ny <= y_hi);
        is_start  = (nx == int'(x_start)) && (ny == int'(y_start));
        is_prev   = (nx == int'(x_prev)) && (ny == int'(y_prev));
        // Length in 4-connected steps, so a cut corner still counts as two pixels
        step_len  = (nbr_dx[nbr_idx[2:0]] != 0 && nbr_dy[nbr_idx[2:0]] != 0) ? 2 : 1;
        scan_end  = (int'(x_pos) == x_hi) && (int'(y_pos) == y_hi);
        if (int'(x_pos) == x_hi) begin
            sx_next = xw'(lo);
            sy_next = y_pos + 1'b1;
        end else begin
            sx_next = x_pos + 1'b1;
            sy_next = y_pos;
        end
    end

    assign pixel_addr    = rd_addr;
    assign visited_addr  = rd_addr;
    assign visited_wdata = 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state             <= st_idle;
            busy              <= 1'b0;
            tracing           <= 1'b0;
            rd_addr           <= '0;
            x_pos             <= '0;
            y_pos             <= '0;
            x_edge            <= '0;
            y_edge            <= '0;
            x_prev            <= '0;
            y_prev            <= '0;
            x_start           <= '0;
            y_start           <= '0;
            nbr_idx           <= '0;
            edge_len          <= '0;
            num_stripes       <= '0;
            bdr_q             <= '0;
            min_len_q         <= '0;
            min_str_q         <= '0;
            visited_we        <= 1'b0;
            detection_valid   <= 1'b0;
            crossing_detected <= 1'b0;
            stripe_count      <= '0;
        end else begin
            visited_we      <= 1'b0;
            detection_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (frame_start) begin
                        bdr_q       <= border;
                        min_len_q   <= min_edge_length;
                        min_str_q   <= min_stripes;
                        busy        <= 1'b1;
                        tracing     <= 1'b0;
                        num_stripes <= '0;
                        x_pos       <= xw'(new_bdr);
                        y_pos       <= yw'(new_bdr);
                        rd_addr     <= addr_of(new_bdr, new_bdr);
                        // Border wider than the frame leaves nothing to scan
                        state       <= new_ok ? st_wait_read : st_report;
                    end
                end
                st_wait_read: begin
                    state <= tracing ? st_follow_edge : st_scan;
                end
                st_scan: begin
                    if (pixel_data && !visited_rdata) begin
                        visited_we <= 1'b1;
                        x_start    <= x_pos;
                        y_start    <= y_pos;
                        x_edge     <= x_pos;
                        y_edge     <= y_pos;
                        x_prev     <= x_pos;
                        y_prev     <= y_pos;
                        edge_len   <= '0;
                        nbr_idx    <= '0;
                        tracing    <= 1'b1;
                        state      <= st_check_nbr;
                    end else if (scan_end) begin
                        state <= st_report;
                    end else begin
                        x_pos   <= sx_next;
                        y_pos   <= sy_next;
                        rd_addr <= addr_of(int'(sx_next), int'(sy_next));
                        state   <= st_wait_read;
                    end
                end
                st_check_nbr: begin
                    if (nbr_idx == 4'(nbr_count)) begin
                        // Chain over, resume the scan after its start pixel
                        tracing <= 1'b0;
                        if (scan_end) begin
                            state <= st_report;
                        end else begin
                            x_pos   <= sx_next;
                            y_pos   <= sy_next;
                            rd_addr <= addr_of(int'(sx_next), int'(sy_next));
                            state   <= st_wait_read;
                        end
                    end else if (in_bounds) begin
                        rd_addr <= addr_of(nx, ny);
                        state   <= st_wait_read;
                    end else begin
                        nbr_idx <= nbr_idx + 1'b1;
                    end
                end
                st_follow_edge: begin
                    state <= st_check_nbr;
                    if (pixel_data && is_start && !is_prev &&
                        (int'(edge_len) + step_len >= int'(min_len_q))) begin
                        if (num_stripes != 8'hff) begin
                            num_stripes <= num_stripes + 1'b1;
                        end
                        nbr_idx <= 4'(nbr_count);
                    end else if (pixel_data && !visited_rdata && !is_prev) begin
                        visited_we <= 1'b1;
                        edge_len   <= edge_len + 16'(step_len);
                        x_prev     <= x_edge;
                        y_prev     <= y_edge;
                        x_edge     <= xw'(nx);
                        y_edge     <= yw'(ny);
                        nbr_idx    <= '0;
                    end else begin
                        nbr_idx <= nbr_idx + 1'b1;
                    end
                end
                st_report: begin
                    stripe_count      <= num_stripes;
                    crossing_detected <= ({8'd0, num_stripes} >= min_str_q);
                    detection_valid   <= 1'b1;
                    busy              <= 1'b0;
                    state             <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/zebra_crossing_top.sv */
`timescale 1ns/1ps
`default_nettype none

module zebra_crossing_top #(
    parameter int img_width    = zc_geom_pkg::default_img_width,
    parameter int img_height   = zc_geom_pkg::default_img_height,
    parameter int credit_count = 4
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  pix_valid,
    input  logic                                  pix_data,
    output logic                                  credit_return,
    input  logic                                  cfg_we,
    input  zc_cfg_pkg::cfg_addr_t                 cfg_addr,
    input  logic [zc_cfg_pkg::cfg_data_width-1:0] cfg_wdata,
    output logic [zc_cfg_pkg::cfg_data_width-1:0] cfg_rdata,
    output logic                                  detection_valid,
    output logic                                  crossing_detected,
    output logic [7:0]                            stripe_count
);
    import zc_cfg_pkg::*;

    localparam int depth = img_width * img_height;
    localparam int aw    = $clog2(depth);

    logic [cfg_data_width-1:0] border, min_edge_length, min_stripes;
    logic                      frame_start, busy;
    logic [aw-1:0]             ld_addr, pixel_addr, visited_addr;
    logic                      ld_img_we, ld_img_wdata, ld_vis_we, ld_vis_wdata;
    logic                      tr_vis_we, tr_vis_wdata;
    logic                      img_rdata, vis_rdata;
    logic [aw-1:0]             img_addr, vis_addr;
    logic                      img_we, vis_we, vis_wdata;

    // Tracer owns both RAM ports while a frame is analysed
    assign img_addr  = busy ? pixel_addr : ld_addr;
    assign img_we    = busy ? 1'b0 : ld_img_we;
    assign vis_addr  = busy ? visited_addr : ld_addr;
    assign vis_we    = busy ? tr_vis_we : ld_vis_we;
    assign vis_wdata = busy ? tr_vis_wdata : ld_vis_wdata;

    zc_cfg_regs u_cfg_regs (
        .clk(clk), .rst_n(rst_n),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
        .border(border), .min_edge_length(min_edge_length), .min_stripes(min_stripes)
    );

    frame_loader #(
        .img_width(img_width), .img_height(img_height), .credit_count(credit_count)
    ) u_frame_loader (
        .clk(clk), .rst_n(rst_n),
        .pix_valid(pix_valid), .pix_data(pix_data), .credit_return(credit_return),
        .detection_valid(detection_valid), .frame_start(frame_start),
        .ram_addr(ld_addr), .img_we(ld_img_we), .img_wdata(ld_img_wdata),
        .vis_we(ld_vis_we), .vis_wdata(ld_vis_wdata)
    );

    bit_ram #(.depth(depth)) u_img_ram (
        .clk(clk), .we(img_we), .addr(img_addr), .wdata(ld_img_wdata), .rdata(img_rdata)
    );

    bit_ram #(.depth(depth)) u_vis_ram (
        .clk(clk), .we(vis_we), .addr(vis_addr), .wdata(vis_wdata), .rdata(vis_rdata)
    );

    contour_tracer #(
        .img_width(img_width), .img_height(img_height)
    ) u_contour_tracer (
        .clk(clk), .rst_n(rst_n), .frame_start(frame_start),
        .border(border), .min_edge_length(min_edge_length), .min_stripes(min_stripes),
        .busy(busy), .pixel_addr(pixel_addr), .pixel_data(img_rdata),
        .visited_addr(visited_addr), .visited_we(tr_vis_we), .visited_wdata(tr_vis_wdata),
        .visited_rdata(vis_rdata), .detection_valid(detection_valid),
        .crossing_detected(crossing_detected), .stripe_count(stripe_count)
    );

endmodule

`default_nettype wire

/* sim/zc_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module zc_asserts #(
    parameter int credit_count = 4,
    parameter int frame_size   = 768
) (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          pix_valid,
    input logic                          credit_return,
    input logic [$clog2(frame_size)-1:0] ram_addr,
    input logic                          vis_we,
    input logic                          vis_wdata
);
    int in_use;
    int wr_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_use <= 0;
        end else begin
            in_use <= in_use + int'(pix_valid) - int'(credit_return);
        end
    end

    // Raster position of the next visited flag to clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_idx <= 0;
        end else if (vis_we) begin
            wr_idx <= (wr_idx + 1) % frame_size;
        end
    end

    credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
        in_use <= credit_count)
        else $error("credits in use exceed the credit count");

    pix_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
        pix_valid |-> (in_use < credit_count))
        else $error("pixel sent without a credit");

    vis_clear: assert property (@(posedge clk) disable iff (!rst_n)
        vis_we |-> (!vis_wdata && int'(ram_addr) == wr_idx))
        else $error("loader wrote the visited RAM with a one or out of raster order");

endmodule

bind frame_loader zc_asserts #(
    .credit_count(credit_count), .frame_size(frame_size)
) u_zc_asserts (
    .clk(clk), .rst_n(rst_n), .pix_valid(pix_valid), .credit_return(credit_return),
    .ram_addr(ram_addr), .vis_we(vis_we), .vis_wdata(vis_wdata)
);

`default_nettype wire

/* sim/tb_zebra_crossing.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_zebra_crossing;
    import zc_geom_pkg::*;
    import zc_cfg_pkg::*;

    localparam int img_w        = default_img_width;
    localparam int img_h        = default_img_height;
    localparam int frame_size   = img_w * img_h;
    localparam int credit_count = 4;
    localparam int bdr          = int'(rst_border);
    localparam int interior     = (img_w - 2 * bdr) * (img_h - 2 * bdr);
    localparam int frames_total = 13;
    localparam int seg_row      = 19;
    // Loading plus ten cycles per interior pixel for every frame, and register setup
    localparam int timeout_limit = frames_total * (frame_size + 10 * interior) + 500;

    logic                      clk;
    logic                      rst_n;
    logic                      pix_valid;
    logic                      pix_data;
    logic                      credit_return;
    logic                      cfg_we;
    cfg_addr_t                 cfg_addr;
    logic [cfg_data_width-1:0] cfg_wdata;
    logic [cfg_data_width-1:0] cfg_rdata;
    logic                      detection_valid;
    logic                      crossing_detected;
    logic [7:0]                stripe_count;

    logic                      img_bits [frame_size];
    int                        rw [8];
    int                        rh [8];
    int                        n_rect;
    int                        px;
    int                        py;
    int                        seg_x;
    logic [31:0]               rng;
    logic [cfg_data_width-1:0] min_len_model;
    logic [cfg_data_width-1:0] min_str_model;
    logic [7:0]                exp_count [frames_total];
    logic                      exp_flag [frames_total];
    int                        frames_sent;
    int                        results_seen;
    int                        pixels_sent;
    int                        returns_seen;
    int                        cycles;

    zebra_crossing_top #(
        .img_width(img_w), .img_height(img_h), .credit_count(credit_count)
    ) u_zebra_crossing_top (
        .clk(clk), .rst_n(rst_n),
        .pix_valid(pix_valid), .pix_data(pix_data), .credit_return(credit_return),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
        .detection_valid(detection_valid), .crossing_detected(crossing_detected),
        .stripe_count(stripe_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_count(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("FAIL stripe_count got %h expected %h", got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("FAIL crossing_detected got %h expected %h", got, exp));
        end
    endtask

    task automatic check_reg(input cfg_addr_t addr, input logic [cfg_data_width-1:0] exp);
        @(posedge clk);
        #2;
        cfg_addr = addr;
        @(negedge clk);
        if (cfg_rdata !== exp) begin
            report_failure($sformatf("FAIL cfg_rdata at address %h got %h expected %h",
                                     addr, cfg_rdata, exp));
        end
    endtask

    task automatic write_reg(input cfg_addr_t addr, input logic [cfg_data_width-1:0] data);
        @(posedge clk);
        #2;
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #2;
        cfg_we = 1'b0;
    endtask

    task automatic set_thresholds(input logic [15:0] min_len, input logic [15:0] min_str);
        write_reg(reg_min_edge, min_len);
        write_reg(reg_min_stripes, min_str);
        min_len_model = min_len;
        min_str_model = min_str;
    endtask

    // LCG, upper half of the state gives the value
    function automatic int rand_range(input int lo, input int hi);
        rng = rng * 32'd1664525 + 32'd1013904223;
        return lo + int'({16'd0, rng[31:16]} % (hi - lo + 1));
    endfunction

    // An outline of w by h has 2w+2h-4 pixels and closes on its start pixel
    function automatic logic [7:0] ref_count(input logic [15:0] min_len);
        int cnt;
        cnt = 0;
        for (int i = 0; i < n_rect; i++) begin
            if (2 * rw[i] + 2 * rh[i] - 4 >= int'(min_len)) begin
                cnt = cnt + 1;
            end
        end
        return (cnt > 255) ? 8'hff : 8'(cnt);
    endfunction

    task automatic clear_frame();
        for (int i = 0; i < frame_size; i++) begin
            img_bits[i] = 1'b0;
        end
        n_rect = 0;
        px     = bdr + 1;
        py     = bdr + 1;
        seg_x  = bdr + 1;
    endtask

    // Outlines go left to right, two black columns apart, and wrap into a lower band
    task automatic place_rect(input int w, input int h);
        if (px + w - 1 > img_w - 1 - bdr) begin
            px = bdr + 1;
            py = py + 8;
        end
        for (int x = px; x < px + w; x++) begin
            img_bits[py * img_w + x]           = 1'b1;
            img_bits[(py + h - 1) * img_w + x] = 1'b1;
        end
        for (int y = py; y < py + h; y++) begin
            img_bits[y * img_w + px]         = 1'b1;
            img_bits[y * img_w + px + w - 1] = 1'b1;
        end
        rw[n_rect] = w;
        rh[n_rect] = h;
        n_rect     = n_rect + 1;
        px         = px + w + 2;
    endtask

    task automatic place_segment(input int len);
        for (int x = seg_x; x < seg_x + len; x++) begin
            img_bits[seg_row * img_w + x] = 1'b1;
        end
        seg_x = seg_x + len + 2;
    endtask

    task automatic random_frame();
        int n;
        clear_frame();
        n = rand_range(0, 5);
        for (int i = 0; i < n; i++) begin
            place_rect(rand_range(3, 6), rand_range(3, 6));
        end
        n = rand_range(0, 3);
        for (int i = 0; i < n; i++) begin
            place_segment(rand_range(2, 6));
        end
    endtask

    task automatic send_frame();
        int i;
        exp_count[frames_sent] = ref_count(min_len_model);
        exp_flag[frames_sent]  = ({8'd0, exp_count[frames_sent]} >= min_str_model);
        i = 0;
        while (i < frame_size) begin
            @(posedge clk);
            #2;
            pix_valid = 1'b0;
            // Occasional idle cycle, otherwise send while a credit is left
            if (rand_range(0, 15) != 0 && pixels_sent - returns_seen < credit_count) begin
                if (i == 0 && results_seen < frames_sent) begin
                    report_failure("A credit for a new frame came before the previous result");
                end
                pix_valid   = 1'b1;
                pix_data    = img_bits[i];
                pixels_sent = pixels_sent + 1;
                i           = i + 1;
            end
        end
        @(posedge clk);
        #2;
        pix_valid   = 1'b0;
        frames_sent = frames_sent + 1;
    endtask

    task automatic wait_results();
        while (results_seen < frames_sent) begin
            @(posedge clk);
        end
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            returns_seen = 0;
        end else if (credit_return) begin
            returns_seen = returns_seen + 1;
            if (returns_seen > pixels_sent) begin
                report_failure("More credits came back than pixels were sent");
            end
        end
    end

    // Result checker
    always @(negedge clk) begin
        if (!rst_n) begin
            results_seen = 0;
        end else if (detection_valid) begin
            if (results_seen >= frames_sent) begin
                report_failure("detection_valid pulsed with no frame waiting for a result");
            end else begin
                check_count(stripe_count, exp_count[results_seen]);
                check_flag(crossing_detected, exp_flag[results_seen]);
                results_seen = results_seen + 1;
            end
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > timeout_limit) begin
                report_failure($sformatf("Timeout after %0d cycles with %0d of %0d results",
                                         cycles, results_seen, frames_sent));
            end
        end
    end

    initial begin
        rng           = 32'h12a6_0770;
        rst_n         = 1'b0;
        pix_valid     = 1'b0;
        pix_data      = 1'b0;
        cfg_we        = 1'b0;
        cfg_addr      = '0;
        cfg_wdata     = '0;
        frames_sent   = 0;
        pixels_sent   = 0;
        min_len_model = rst_min_edge;
        min_str_model = rst_min_stripes;
        clear_frame();
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_count(stripe_count, 8'd0);
        check_flag(crossing_detected, 1'b0);

        // Register reset values, then read-back of written values
        check_reg(reg_border, rst_border);
        check_reg(reg_min_edge, rst_min_edge);
        check_reg(reg_min_stripes, rst_min_stripes);
        check_reg(2'd3, 16'h0000);
        write_reg(reg_border, 16'h0005);
        write_reg(reg_min_edge, 16'h0014);
        write_reg(reg_min_stripes, 16'h0007);
        write_reg(2'd3, 16'hbeef);
        check_reg(reg_border, 16'h0005);
        check_reg(reg_min_edge, 16'h0014);
        check_reg(reg_min_stripes, 16'h0007);
        check_reg(2'd3, 16'h0000);
        write_reg(reg_border, rst_border);
        set_thresholds(rst_min_edge, rst_min_stripes);

        clear_frame();
        place_rect(4, 4);
        place_rect(5, 3);
        place_rect(6, 6);
        place_rect(3, 5);
        send_frame();
        wait_results();

        clear_frame();
        place_segment(4);
        place_segment(5);
        place_segment(6);
        place_rect(5, 4);
        place_rect(4, 4);
        send_frame();
        wait_results();

        // Longer minimum edge drops the small outlines, then a lower stripe limit
        set_thresholds(16'd16, 16'd3);
        clear_frame();
        place_rect(3, 3);
        place_rect(4, 4);
        place_rect(6, 5);
        place_rect(6, 6);
        place_rect(5, 4);
        send_frame();
        wait_results();
        set_thresholds(16'd16, 16'd2);
        send_frame();
        wait_results();
        set_thresholds(rst_min_edge, rst_min_stripes);

        for (int f = 0; f < 8; f++) begin
            random_frame();
            send_frame();
        end
        wait_results();

        clear_frame();
        send_frame();
        wait_results();

        repeat (8) @(posedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
design/zc_geom_pkg.sv
design/zc_cfg_pkg.sv
design/zc_cfg_regs.sv
design/frame_loader.sv
design/bit_ram.sv
design/contour_tracer.sv
design/zebra_crossing_top.sv
sim/zc_asserts.sv
sim/tb_zebra_crossing.sv

/* run_sim.sh */
#!/bin/sh
rm -f sim.log && \
verilator --binary --timing --assert -Wno-fatal --top-module tb_zebra_crossing \
    -f flist.f -o vsim && \
./obj_dir/vsim 2>&1 | tee sim.log
grep -q '^NO ERRORS$' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
